// File: verilog/datapathPkg.sv
package datapathPkg;

    // Width of the bus, the registers and every memory word.
    localparam int wordWidth = 32;

    // General purpose registers R0 to R15.
    localparam int regCount = 16;

    // Operations the ALU can perform. The opcode is mapped onto these in the ALU,
    // so several instructions share one operation.
    typedef enum logic [3:0] {
        add   = 4'd0,
        sub   = 4'd1,
        andOp = 4'd2,
        orOp  = 4'd3,
        shr   = 4'd4,
        shl   = 4'd5,
        neg   = 4'd6,
        notOp = 4'd7,
        inc   = 4'd8
    } aluOpT;

endpackage

// File: verilog/isaPkg.sv
package isaPkg;

    // Width of the sign-extended constant field in the immediate format.
    localparam int constBits = 19;

    typedef enum logic [4:0] {
        ld    = 5'b00000,
        ldi   = 5'b00001,
        st    = 5'b00010,
        add   = 5'b00011,
        sub   = 5'b00100,
        andOp = 5'b00101,
        orOp  = 5'b00110,
        shr   = 5'b01001,
        shl   = 5'b01011,
        addi  = 5'b01100,
        andi  = 5'b01101,
        ori   = 5'b01110,
        neg   = 5'b10001,
        notOp = 5'b10010
    } opcodeT;

    // Three-register format used by the ALU instructions.
    typedef struct packed {
        opcodeT      opcode;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [14:0] unused;
    } rFmtT;

    // Register plus constant format used by loads, stores and immediates.
    typedef struct packed {
        opcodeT                 opcode;
        logic [3:0]             ra;
        logic [3:0]             rb;
        logic [constBits-1:0]   c;
    } iFmtT;

    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
    } instrT;

endpackage

// File: verilog/selectEncode.sv
`timescale 1ns/1ps

module selectEncode (
    input  isaPkg::instrT                          ir,
    input  logic                                   gra,
    input  logic                                   grb,
    input  logic                                   grc,
    input  logic                                   rIn,
    input  logic                                   rOut,
    input  logic                                   baOut,
    output logic [datapathPkg::regCount-1:0]       regWriteEn,
    output logic [datapathPkg::regCount-1:0]       regReadEn,
    output logic [datapathPkg::wordWidth-1:0]      cSignExt
);

    localparam int selBits = $clog2(datapathPkg::regCount);

    logic [selBits-1:0]               regSel;
    logic                             anySel;
    logic [datapathPkg::regCount-1:0] regDecoded;

    // The testbench raises at most one of the selects, so an AND-OR mux suffices.
    assign regSel = ({selBits{gra}} & ir.rFmt.ra)
                  | ({selBits{grb}} & ir.rFmt.rb)
                  | ({selBits{grc}} & ir.rFmt.rc);

    assign anySel = gra | grb | grc;

    always_comb begin
        regDecoded = '0;
        if (anySel) begin
            regDecoded[regSel] = 1'b1;
        end
    end

    assign regWriteEn = rIn ? regDecoded : '0;
    assign regReadEn  = (rOut | baOut) ? regDecoded : '0;

    // Constant field taken through the immediate view and widened to a full word.
    assign cSignExt = {{(datapathPkg::wordWidth - isaPkg::constBits){ir.iFmt.c[isaPkg::constBits-1]}},
                       ir.iFmt.c};

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                                Clock,
    input  logic                                rstN,
    input  logic [datapathPkg::wordWidth-1:0]   busValue,
    input  logic [datapathPkg::regCount-1:0]    regWriteEn,
    input  logic [datapathPkg::regCount-1:0]    regReadEn,
    input  logic                                baOut,
    output logic [datapathPkg::wordWidth-1:0]   readData
);

    logic [datapathPkg::wordWidth-1:0] regs [datapathPkg::regCount];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < datapathPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < datapathPkg::regCount; i++) begin
                if (regWriteEn[i]) begin
                    regs[i] <= busValue;
                end
            end
        end
    end

    // The read enable is one-hot, so ORing the enabled registers selects one.
    // Under baOut R0 contributes nothing and the base reads as zero.
    always_comb begin
        readData = '0;
        for (int i = 0; i < datapathPkg::regCount; i++) begin
            if (regReadEn[i] && !(i == 0 && baOut)) begin
                readData = readData | regs[i];
            end
        end
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [datapathPkg::wordWidth-1:0]   yValue,
    input  logic [datapathPkg::wordWidth-1:0]   busValue,
    input  isaPkg::opcodeT                      opcode,
    input  logic                                incPc,
    output logic [datapathPkg::wordWidth-1:0]   result
);

    localparam int shiftBits = $clog2(datapathPkg::wordWidth);

    datapathPkg::aluOpT   aluOp;
    logic [shiftBits-1:0] shiftAmount;

    assign shiftAmount = busValue[shiftBits-1:0];

    // Loads, stores and immediates all need an address or sum, hence add.
    always_comb begin
        if (incPc) begin
            aluOp = datapathPkg::inc;
        end else begin
            case (opcode)
                isaPkg::ld,
                isaPkg::ldi,
                isaPkg::st,
                isaPkg::add,
                isaPkg::addi:  aluOp = datapathPkg::add;
                isaPkg::sub:   aluOp = datapathPkg::sub;
                isaPkg::andOp,
                isaPkg::andi:  aluOp = datapathPkg::andOp;
                isaPkg::orOp,
                isaPkg::ori:   aluOp = datapathPkg::orOp;
                isaPkg::shr:   aluOp = datapathPkg::shr;
                isaPkg::shl:   aluOp = datapathPkg::shl;
                isaPkg::neg:   aluOp = datapathPkg::neg;
                isaPkg::notOp: aluOp = datapathPkg::notOp;
                default:       aluOp = datapathPkg::add;
            endcase
        end
    end

    always_comb begin
        case (aluOp)
            datapathPkg::add:   result = yValue + busValue;
            datapathPkg::sub:   result = yValue - busValue;
            datapathPkg::andOp: result = yValue & busValue;
            datapathPkg::orOp:  result = yValue | busValue;
            datapathPkg::shr:   result = yValue >> shiftAmount;
            datapathPkg::shl:   result = yValue << shiftAmount;
            datapathPkg::neg:   result = -busValue;
            datapathPkg::notOp: result = ~busValue;
            datapathPkg::inc:   result = busValue + 1'b1;
            default:            result = yValue + busValue;
        endcase
    end

endmodule

// File: verilog/memoryUnit.sv
`timescale 1ns/1ps

module memoryUnit #(
    parameter int memAddrBits = 9
) (
    input  logic                                Clock,
    input  logic                                rstN,
    input  logic [datapathPkg::wordWidth-1:0]   busValue,
    input  logic [datapathPkg::wordWidth-1:0]   mdatain,
    input  logic                                marIn,
    input  logic                                mdrIn,
    input  logic                                read,
    input  logic                                write,
    output logic [datapathPkg::wordWidth-1:0]   mdrValue
);

    localparam int memWords = 2 ** memAddrBits;

    logic [datapathPkg::wordWidth-1:0] mar;
    logic [datapathPkg::wordWidth-1:0] mdr;
    logic [datapathPkg::wordWidth-1:0] ram [memWords];
    logic [memAddrBits-1:0]            memAddr;
    logic [datapathPkg::wordWidth-1:0] memData;

    // Only the low MAR bits reach the RAM, higher addresses wrap.
    assign memAddr = mar[memAddrBits-1:0];
    assign memData = ram[memAddr];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (marIn) begin
                mar <= busValue;
            end
            if (mdrIn) begin
                mdr <= read ? memData : mdatain;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (write) begin
            ram[memAddr] <= mdr;
        end
    end

    assign mdrValue = mdr;

endmodule

// File: verilog/busDatapath.sv
`timescale 1ns/1ps

module busDatapath #(
    parameter int memAddrBits = 9
) (
    input  logic                                Clock,
    input  logic                                rstN,
    // Bus sources, one-hot or all zero.
    input  logic                                pcOut,
    input  logic                                zOut,
    input  logic                                mdrOut,
    input  logic                                inPortOut,
    input  logic                                cOut,
    input  logic                                rOut,
    // Bus destinations.
    input  logic                                pcIn,
    input  logic                                irIn,
    input  logic                                yIn,
    input  logic                                zIn,
    input  logic                                marIn,
    input  logic                                mdrIn,
    input  logic                                outPortIn,
    input  logic                                rIn,
    input  logic                                incPc,
    input  logic                                read,
    input  logic                                write,
    input  logic                                gra,
    input  logic                                grb,
    input  logic                                grc,
    input  logic                                baOut,
    input  logic [datapathPkg::wordWidth-1:0]   inPort,
    input  logic [datapathPkg::wordWidth-1:0]   mdatain,
    output logic [datapathPkg::wordWidth-1:0]   outPort
);

    localparam int w = datapathPkg::wordWidth;

    logic [w-1:0]                     pc;
    isaPkg::instrT                    ir;
    logic [w-1:0]                     y;
    logic [w-1:0]                     z;
    logic [w-1:0]                     busValue;
    logic [w-1:0]                     readData;
    logic [w-1:0]                     cSignExt;
    logic [w-1:0]                     mdrValue;
    logic [w-1:0]                     result;
    logic [datapathPkg::regCount-1:0] regWriteEn;
    logic [datapathPkg::regCount-1:0] regReadEn;

    // Sources are one-hot, so an AND-OR mux gives zero when nothing drives.
    assign busValue = ({w{pcOut}}          & pc)
                    | ({w{zOut}}           & z)
                    | ({w{mdrOut}}         & mdrValue)
                    | ({w{inPortOut}}      & inPort)
                    | ({w{cOut}}           & cSignExt)
                    | ({w{rOut | baOut}}   & readData);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc      <= '0;
            ir      <= '0;
            y       <= '0;
            z       <= '0;
            outPort <= '0;
        end else begin
            if (pcIn) pc <= busValue;
            if (irIn) ir <= busValue;
            if (yIn) y <= busValue;
            if (zIn) z <= result;
            if (outPortIn) outPort <= busValue;
        end
    end

    selectEncode u_selectEncode (
        .ir         (ir),
        .gra        (gra),
        .grb        (grb),
        .grc        (grc),
        .rIn        (rIn),
        .rOut       (rOut),
        .baOut      (baOut),
        .regWriteEn (regWriteEn),
        .regReadEn  (regReadEn),
        .cSignExt   (cSignExt)
    );

    registerFile u_registerFile (
        .Clock      (Clock),
        .rstN       (rstN),
        .busValue   (busValue),
        .regWriteEn (regWriteEn),
        .regReadEn  (regReadEn),
        .baOut      (baOut),
        .readData   (readData)
    );

    alu u_alu (
        .yValue   (y),
        .busValue (busValue),
        .opcode   (ir.rFmt.opcode),
        .incPc    (incPc),
        .result   (result)
    );

    memoryUnit #(
        .memAddrBits (memAddrBits)
    ) u_memoryUnit (
        .Clock    (Clock),
        .rstN     (rstN),
        .busValue (busValue),
        .mdatain  (mdatain),
        .marIn    (marIn),
        .mdrIn    (mdrIn),
        .read     (read),
        .write    (write),
        .mdrValue (mdrValue)
    );

endmodule

// File: include/microSteps.svh
`ifndef MICRO_STEPS_SVH
`define MICRO_STEPS_SVH

// One bit per strobe, sources first, then destinations, then the other controls.
localparam int stepBits = 21;

localparam logic [stepBits-1:0] mPcOut     = 21'h1 << 0;
localparam logic [stepBits-1:0] mZOut      = 21'h1 << 1;
localparam logic [stepBits-1:0] mMdrOut    = 21'h1 << 2;
localparam logic [stepBits-1:0] mInPortOut = 21'h1 << 3;
localparam logic [stepBits-1:0] mCOut      = 21'h1 << 4;
localparam logic [stepBits-1:0] mROut      = 21'h1 << 5;
localparam logic [stepBits-1:0] mPcIn      = 21'h1 << 6;
localparam logic [stepBits-1:0] mIrIn      = 21'h1 << 7;
localparam logic [stepBits-1:0] mYIn       = 21'h1 << 8;
localparam logic [stepBits-1:0] mZIn       = 21'h1 << 9;
localparam logic [stepBits-1:0] mMarIn     = 21'h1 << 10;
localparam logic [stepBits-1:0] mMdrIn     = 21'h1 << 11;
localparam logic [stepBits-1:0] mOutPortIn = 21'h1 << 12;
localparam logic [stepBits-1:0] mRIn       = 21'h1 << 13;
localparam logic [stepBits-1:0] mIncPc     = 21'h1 << 14;
localparam logic [stepBits-1:0] mRead      = 21'h1 << 15;
localparam logic [stepBits-1:0] mWrite     = 21'h1 << 16;
localparam logic [stepBits-1:0] mGra       = 21'h1 << 17;
localparam logic [stepBits-1:0] mGrb       = 21'h1 << 18;
localparam logic [stepBits-1:0] mGrc       = 21'h1 << 19;
localparam logic [stepBits-1:0] mBaOut     = 21'h1 << 20;

localparam logic [stepBits-1:0] stepIdle   = '0;
localparam logic [stepBits-1:0] stepFetch0 = mPcOut | mMarIn | mIncPc | mZIn;
localparam logic [stepBits-1:0] stepFetch1 = mZOut | mPcIn | mRead | mMdrIn;
localparam logic [stepBits-1:0] stepFetch2 = mMdrOut | mIrIn;

// Presets move inPort into MAR or a register and mdatain through MDR into RAM.
localparam logic [stepBits-1:0] stepSetMar = mInPortOut | mMarIn;
localparam logic [stepBits-1:0] stepSetMdr = mMdrIn;
localparam logic [stepBits-1:0] stepSetReg = mInPortOut | mGra | mRIn;
localparam logic [stepBits-1:0] stepMemWr  = mWrite;

// Address and ALU phases.
localparam logic [stepBits-1:0] stepBaseY  = mGrb | mBaOut | mYIn;
localparam logic [stepBits-1:0] stepRbY    = mGrb | mROut | mYIn;
localparam logic [stepBits-1:0] stepConstZ = mCOut | mZIn;
localparam logic [stepBits-1:0] stepRcZ    = mGrc | mROut | mZIn;
localparam logic [stepBits-1:0] stepUnaryZ = mGrb | mROut | mZIn;
localparam logic [stepBits-1:0] stepZMar   = mZOut | mMarIn;
localparam logic [stepBits-1:0] stepMemRd  = mRead | mMdrIn;
localparam logic [stepBits-1:0] stepMdrRa  = mMdrOut | mGra | mRIn;
localparam logic [stepBits-1:0] stepZRa    = mZOut | mGra | mRIn;
localparam logic [stepBits-1:0] stepShowRa = mGra | mROut | mOutPortIn;
localparam logic [stepBits-1:0] stepShowMdr = mMdrOut | mOutPortIn;

`endif

// File: verif/datapathTb.sv
`timescale 1ns/1ps

module datapathTb;

    `include "microSteps.svh"

    typedef logic [datapathPkg::wordWidth-1:0] wordT;
    typedef logic [isaPkg::constBits-1:0] constT;

    logic Clock;
    logic rstN;
    logic pcOut, zOut, mdrOut, inPortOut, cOut, rOut;
    logic pcIn, irIn, yIn, zIn, marIn, mdrIn, outPortIn, rIn;
    logic incPc, read, write, gra, grb, grc, baOut;
    logic [stepBits-1:0] ctrl;
    wordT inPort;
    wordT mdatain;
    wordT outPort;

    // Test t owns the steps from firstStep[t] up to lastStep[t], the last one excluded.
    logic [stepBits-1:0] stepQ[$];
    wordT dataQ[$];
    string names[$];
    int firstStep[$];
    int lastStep[$];
    bit instrCheck[$];
    wordT expected[$];

    logic [31:0] seed = 32'h3b8b_e840;
    int budgetCycles = 0;
    int passCount = 0;
    int failCount = 0;
    bit testOk;

    // The strobe word packs sources in the low bits and the other controls in the high bits.
    assign {baOut, grc, grb, gra, write, read, incPc, rIn} = ctrl[20:13];
    assign {outPortIn, mdrIn, marIn, zIn, yIn, irIn, pcIn} = ctrl[12:6];
    assign {rOut, cOut, inPortOut, mdrOut, zOut, pcOut} = ctrl[5:0];

    busDatapath #(.memAddrBits(9)) u_busDatapath (.*);

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    function automatic wordT nextRand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // A set sign bit makes the field worth its unsigned value minus 2^19.
    function automatic wordT sext(constT c);
        if (c[isaPkg::constBits-1]) begin
            return wordT'(c) - (wordT'(1) << isaPkg::constBits);
        end else begin
            return wordT'(c);
        end
    endfunction

    function automatic isaPkg::instrT immWord(isaPkg::opcodeT op, logic [3:0] ra,
                                              logic [3:0] rb, constT c);
        isaPkg::instrT w;
        w.iFmt.opcode = op;
        w.iFmt.ra = ra;
        w.iFmt.rb = rb;
        w.iFmt.c = c;
        return w;
    endfunction

    function automatic isaPkg::instrT regWord(isaPkg::opcodeT op, logic [3:0] ra,
                                              logic [3:0] rb, logic [3:0] rc);
        isaPkg::instrT w;
        w.rFmt.opcode = op;
        w.rFmt.ra = ra;
        w.rFmt.rb = rb;
        w.rFmt.rc = rc;
        w.rFmt.unused = '0;
        return w;
    endfunction

    // Reference model. Address forming instructions all reduce to an add.
    function automatic datapathPkg::aluOpT opFor(isaPkg::opcodeT op);
        case (op)
            isaPkg::sub:                 return datapathPkg::sub;
            isaPkg::andOp, isaPkg::andi: return datapathPkg::andOp;
            isaPkg::orOp, isaPkg::ori:   return datapathPkg::orOp;
            isaPkg::shr:                 return datapathPkg::shr;
            isaPkg::shl:                 return datapathPkg::shl;
            isaPkg::neg:                 return datapathPkg::neg;
            isaPkg::notOp:               return datapathPkg::notOp;
            default:                     return datapathPkg::add;
        endcase
    endfunction

    function automatic wordT refAlu(datapathPkg::aluOpT op, wordT y, wordT b);
        case (op)
            datapathPkg::sub:   return y - b;
            datapathPkg::andOp: return y & b;
            datapathPkg::orOp:  return y | b;
            datapathPkg::shr:   return y >> b[4:0];
            datapathPkg::shl:   return y << b[4:0];
            datapathPkg::neg:   return ~b + 32'd1;
            datapathPkg::notOp: return ~b;
            datapathPkg::inc:   return b + 32'd1;
            default:            return y + b;
        endcase
    endfunction

    task automatic pushStep(logic [stepBits-1:0] s, wordT d);
        stepQ.push_back(s);
        dataQ.push_back(d);
    endtask

    task automatic beginRow(string name);
        names.push_back(name);
        firstStep.push_back(stepQ.size());
    endtask

    task automatic endRow(logic [stepBits-1:0] showStep, bit isInstr, wordT want);
        pushStep(showStep, '0);
        lastStep.push_back(stepQ.size());
        instrCheck.push_back(isInstr);
        expected.push_back(want);
    endtask

    // Registers are only reachable through ra, so a helper word goes into IR first.
    task automatic presetReg(logic [3:0] idx, wordT value);
        pushStep(mInPortOut | mIrIn, wordT'(immWord(isaPkg::ldi, idx, 4'd0, '0)));
        pushStep(stepSetReg, value);
    endtask

    task automatic presetMem(wordT addr, wordT value);
        pushStep(stepSetMar, addr);
        pushStep(stepSetMdr, value);
        pushStep(stepMemWr, '0);
    endtask

    task automatic loadIr(isaPkg::instrT instr);
        pushStep(mInPortOut | mIrIn, wordT'(instr));
    endtask

    task automatic loadSteps();
        pushStep(stepBaseY, '0);
        pushStep(stepConstZ, '0);
        pushStep(stepZMar, '0);
        pushStep(stepMemRd, '0);
        pushStep(stepMdrRa, '0);
    endtask

    task automatic loadRow(string name, logic [3:0] ra, logic [3:0] rb, wordT base, constT c);
        wordT addr;
        wordT word;
        addr = ((rb == 4'd0) ? wordT'(0) : base) + sext(c);
        word = nextRand();
        beginRow(name);
        presetReg(rb, base);
        presetMem(addr, word);
        loadIr(immWord(isaPkg::ld, ra, rb, c));
        loadSteps();
        endRow(stepShowRa, 1'b0, word);
    endtask

    task automatic immRow(string name, isaPkg::opcodeT op, logic [3:0] rb, wordT a, constT c);
        wordT y;
        y = (op == isaPkg::ldi && rb == 4'd0) ? wordT'(0) : a;
        beginRow(name);
        presetReg(rb, a);
        loadIr(immWord(op, 4'd2, rb, c));
        pushStep((op == isaPkg::ldi) ? stepBaseY : stepRbY, '0);
        pushStep(stepConstZ, '0);
        pushStep(stepZRa, '0);
        endRow(stepShowRa, 1'b0, refAlu(opFor(op), y, sext(c)));
    endtask

    task automatic aluRow(string name, isaPkg::opcodeT op, wordT a, wordT b);
        wordT want;
        beginRow(name);
        presetReg(4'd4, a);
        presetReg(4'd5, b);
        loadIr(regWord(op, 4'd3, 4'd4, 4'd5));
        if (op == isaPkg::neg || op == isaPkg::notOp) begin
            pushStep(stepUnaryZ, '0);
            want = refAlu(opFor(op), '0, a);
        end else begin
            pushStep(stepRbY, '0);
            pushStep(stepRcZ, '0);
            want = refAlu(opFor(op), a, b);
        end
        pushStep(stepZRa, '0);
        endRow(stepShowRa, 1'b0, want);
    endtask

    // Stores R9 at R10+c, then loads the same address back into R11.
    task automatic storeRow(string name, wordT base, constT c, wordT value);
        beginRow(name);
        presetReg(4'd10, base);
        presetReg(4'd9, value);
        loadIr(immWord(isaPkg::st, 4'd9, 4'd10, c));
        pushStep(stepBaseY, '0);
        pushStep(stepConstZ, '0);
        pushStep(stepZMar, '0);
        // MDR takes write data from mdatain, which carries the value held in R9.
        pushStep(stepSetMdr, value);
        pushStep(stepMemWr, '0);
        loadIr(immWord(isaPkg::ld, 4'd11, 4'd10, c));
        loadSteps();
        endRow(stepShowRa, 1'b0, value);
    endtask

    task automatic buildTable();
        isaPkg::instrT w0;
        isaPkg::instrT w1;
        w0 = immWord(isaPkg::ld, 4'd1, 4'd2, 19'd5);
        w1 = regWord(isaPkg::add, 4'd3, 4'd4, 4'd5);
        // The fetch rows run first, while PC still holds its reset value.
        beginRow("fetch addr 0");
        presetMem(32'd0, wordT'(w0));
        presetMem(32'd1, wordT'(w1));
        pushStep(stepFetch0, '0);
        pushStep(stepFetch1, '0);
        pushStep(stepFetch2, '0);
        endRow(stepShowMdr, 1'b1, wordT'(w0));
        beginRow("fetch addr 1");
        pushStep(stepFetch0, '0);
        pushStep(stepFetch1, '0);
        pushStep(stepFetch2, '0);
        endRow(stepShowMdr, 1'b1, wordT'(w1));
        loadRow("ld base plus c", 4'd6, 4'd7, 32'd200, 19'd12);
        loadRow("ld negative c", 4'd6, 4'd7, 32'd300, 19'h7fff8);
        loadRow("ld zero base", 4'd8, 4'd0, nextRand() | 32'd1, 19'd40);
        immRow("ldi", isaPkg::ldi, 4'd7, nextRand(), 19'd100);
        immRow("ldi negative c", isaPkg::ldi, 4'd7, nextRand(), 19'h7ff00);
        immRow("ldi zero base", isaPkg::ldi, 4'd0, nextRand() | 32'd1, 19'h7fff0);
        immRow("addi", isaPkg::addi, 4'd13, nextRand(), 19'd77);
        immRow("addi negative c", isaPkg::addi, 4'd13, nextRand(), 19'h7ffff);
        aluRow("add", isaPkg::add, nextRand(), nextRand());
        aluRow("sub", isaPkg::sub, nextRand(), nextRand());
        aluRow("and", isaPkg::andOp, nextRand(), nextRand());
        aluRow("or", isaPkg::orOp, nextRand(), nextRand());
        aluRow("shl", isaPkg::shl, nextRand(), nextRand());
        aluRow("shr", isaPkg::shr, nextRand(), nextRand());
        aluRow("neg", isaPkg::neg, nextRand(), nextRand());
        aluRow("not", isaPkg::notOp, nextRand(), nextRand());
        storeRow("st round trip", 32'd150, 19'd7, nextRand());
        storeRow("st negative c", 32'd150, 19'h7fffd, nextRand());
        immRow("andi", isaPkg::andi, 4'd13, nextRand(), constT'(nextRand()));
        immRow("ori", isaPkg::ori, 4'd13, nextRand(), constT'(nextRand()));
    endtask

    task automatic applyStep(logic [stepBits-1:0] s, wordT d);
        @(posedge Clock);
        #1;
        ctrl = s;
        inPort = d;
        mdatain = d;
    endtask

    task automatic compareWord(wordT want, wordT got);
        if (got !== want) begin
            $display("[ERROR] outPort expected %h actual %h", want, got);
            testOk = 1'b0;
        end
    endtask

    task automatic compareInstr(isaPkg::instrT want, isaPkg::instrT got);
        if (got !== want) begin
            $display("[ERROR] outPort expected %h actual %h", want, got);
            testOk = 1'b0;
        end
    endtask

    task automatic reportTest(string name);
        if (testOk) begin
            passCount++;
            $display("PASS %s", name);
        end else begin
            failCount++;
            $display("FAIL %s", name);
        end
    endtask

    initial begin
        wait (budgetCycles > 0);
        repeat (budgetCycles) @(posedge Clock);
        $display("Timeout: the tests did not finish within %0d clock cycles.", budgetCycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        ctrl = '0;
        inPort = '0;
        mdatain = '0;
        rstN = 1'b0;
        buildTable();
        budgetCycles = stepQ.size() + names.size() + 3 + 20;
        repeat (3) @(posedge Clock);
        #1;
        rstN = 1'b1;
        testOk = 1'b1;
        compareWord('0, outPort);
        reportTest("reset");
        for (int t = 0; t < names.size(); t++) begin
            testOk = 1'b1;
            for (int k = firstStep[t]; k < lastStep[t]; k++) begin
                applyStep(stepQ[k], dataQ[k]);
            end
            applyStep(stepIdle, '0);
            if (instrCheck[t]) begin
                compareInstr(isaPkg::instrT'(expected[t]), isaPkg::instrT'(outPort));
            end else begin
                compareWord(expected[t], outPort);
            end
            reportTest(names[t]);
        end
        $display("Summary: %0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
verilog/datapathPkg.sv
verilog/isaPkg.sv
verilog/selectEncode.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/memoryUnit.sv
verilog/busDatapath.sv
verif/datapathTb.sv

// File: Makefile
# Verilator build and run for the bus datapath testbench.

VERILATOR ?= verilator
TOP       ?= datapathTb
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory $(OBJDIR)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJDIR)
